// ==== verilog.f ====
+incdir+test
source/mx_pkg.sv
source/row_ram.sv
source/n2r_buffer_i.sv
source/n2r_input_stage.sv
test/tb_n2r_input_stage.sv

// ==== Makefile ====
# Verilator lint and simulation for the input reshaping stage

VERILATOR ?= verilator
TOP       ?= tb_n2r_input_stage
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Test OK

SOURCES := $(wildcard source/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_model.svh ====
// Reference model for the reshaping buffer
// Turns the accepted matrix into expected beats and pair_done flags
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Matrix as accepted during fill
mx_pkg::row_t        model_rows [mx_pkg::ROWS];
mx_pkg::slice_beat_t exp_beats [$];
logic                exp_pair [$];

// Block whose top-left element sits at row 2p, column col
function automatic mx_pkg::block_t make_block(input int p, input int col);
    mx_pkg::block_t blk;
    mx_pkg::row_t   upper;
    mx_pkg::row_t   lower;
    upper = model_rows[mx_pkg::BLOCK * p];
    lower = model_rows[mx_pkg::BLOCK * p + 1];
    blk.top_left  = upper[mx_pkg::col_addr_t'(col)];
    blk.top_right = upper[mx_pkg::col_addr_t'(col + 1)];
    blk.bot_left  = lower[mx_pkg::col_addr_t'(col)];
    blk.bot_right = lower[mx_pkg::col_addr_t'(col + 1)];
    return blk;
endfunction

// Column group runs inside the row pair
task automatic build_expected();
    mx_pkg::slice_beat_t beat;
    for (int p = 0; p < mx_pkg::PAIRS; p++) begin
        for (int g = 0; g < mx_pkg::GROUPS; g++) begin
            for (int c = 0; c < mx_pkg::NUM_CORES; c++) begin
                beat[c] = make_block(p, mx_pkg::BLOCK * (g * mx_pkg::NUM_CORES + c));
            end
            exp_beats.push_back(beat);
            exp_pair.push_back(g == mx_pkg::GROUPS - 1);
        end
    end
endtask

`endif

// ==== test/tb_n2r_input_stage.sv ====
// Testbench for the input reshaping stage
// Random matrices checked against a reference model, plus stray strobes
`timescale 1ns/10ps

module tb_n2r_input_stage;

    logic                clk;
    logic                rst_n;
    logic                start;
    logic                row_valid;
    mx_pkg::row_t        in_row;
    logic                out_valid;
    logic                pair_done;
    logic                done;
    logic                busy;
    mx_pkg::slice_beat_t out_beat;

    integer seed;
    int     errors;
    int     tests;
    int     failed;
    int     beats_seen;
    int     done_seen;
    logic   prev_valid;
    bit     timed_out;

    `include "tb_model.svh"

    n2r_input_stage u_n2r_input_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .row_valid (row_valid),
        .in_row    (in_row),
        .out_valid (out_valid),
        .pair_done (pair_done),
        .done      (done),
        .busy      (busy),
        .out_beat  (out_beat)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_beat(input string name, input mx_pkg::slice_beat_t exp,
                              input mx_pkg::slice_beat_t act);
        if (act !== exp) begin
            $display("MISMATCH %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // Output monitor sampled away from the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                beats_seen++;
                check_flag("busy", 1'b1, busy);
                if (exp_beats.size() == 0) begin
                    $display("%0t: a beat arrived when none was expected", $time);
                    errors++;
                end else begin
                    check_beat("out_beat", exp_beats.pop_front(), out_beat);
                    check_flag("pair_done", exp_pair.pop_front(), pair_done);
                end
            end else begin
                check_flag("pair_done", 1'b0, pair_done);
            end
            if (done) begin
                done_seen++;
                check_flag("busy", 1'b0, busy);
                check_flag("out_valid before done", 1'b1, prev_valid);
                if (exp_beats.size() != 0) begin
                    $display("%0t: done pulsed with %0d beats still expected", $time,
                             exp_beats.size());
                    errors++;
                end
            end
            prev_valid = out_valid;
        end
    end

    task automatic random_row(output mx_pkg::row_t row);
        for (int c = 0; c < mx_pkg::COLS; c++) begin
            row[c] = mx_pkg::elem_t'($random(seed));
        end
    endtask

    // One row strobe after a random gap of 0 to 3 cycles
    task automatic send_row(input mx_pkg::row_t row, input bit with_start);
        int gap;
        gap = $random(seed) & 3;
        repeat (gap) @(negedge clk);
        row_valid = 1'b1;
        in_row    = row;
        start     = with_start;
        @(negedge clk);
        row_valid = 1'b0;
        start     = 1'b0;
    endtask

    task automatic wait_for_done(input int limit);
        int n;
        n = 0;
        while (!done && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("%0t: timeout, done did not pulse within %0d cycles", $time, limit);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_matrix(input bit stray, input bit extra_start);
        mx_pkg::row_t junk;
        int           beats0;
        int           done0;
        if (timed_out) return;
        // Rows before start must not land in the matrix
        if (stray) begin
            for (int r = 0; r < mx_pkg::ROWS; r++) begin
                random_row(junk);
                send_row(junk, 1'b0);
            end
        end
        for (int r = 0; r < mx_pkg::ROWS; r++) begin
            random_row(model_rows[r]);
        end
        build_expected();
        beats0 = beats_seen;
        done0  = done_seen;
        start  = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int r = 0; r < mx_pkg::ROWS; r++) begin
            send_row(model_rows[r], extra_start && r == 3);
        end
        wait_for_done(4 * mx_pkg::BEATS + 16);
        repeat (3) @(negedge clk);
        check_flag("busy", 1'b0, busy);
        if (!timed_out) begin
            if (beats_seen - beats0 != mx_pkg::BEATS) begin
                $display("%0t: got %0d beats instead of %0d", $time,
                         beats_seen - beats0, mx_pkg::BEATS);
                errors++;
            end
            if (done_seen - done0 != 1) begin
                $display("%0t: done pulsed %0d times instead of once", $time, done_seen - done0);
                errors++;
            end
            if (exp_beats.size() != 0) begin
                $display("%0t: %0d expected beats never arrived", $time, exp_beats.size());
                errors++;
            end
        end
        exp_beats.delete();
        exp_pair.delete();
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        if (errors != err0) begin
            failed++;
            $display("test %0d %s: failed with %0d errors", tests, name, errors - err0);
        end else begin
            $display("test %0d %s: passed", tests, name);
        end
    endtask

    initial begin
        int err0;
        seed       = 32'he3e3_72ad;
        rst_n      = 1'b0;
        start      = 1'b0;
        row_valid  = 1'b0;
        in_row     = '0;
        errors     = 0;
        tests      = 0;
        failed     = 0;
        beats_seen = 0;
        done_seen  = 0;
        prev_valid = 1'b0;
        timed_out  = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        err0 = errors;
        repeat (20) begin
            @(negedge clk);
            check_flag("out_valid", 1'b0, out_valid);
            check_flag("pair_done", 1'b0, pair_done);
            check_flag("done", 1'b0, done);
            check_flag("busy", 1'b0, busy);
        end
        end_test("reset state", err0);

        err0 = errors;
        run_matrix(1'b0, 1'b0);
        end_test("single matrix", err0);

        err0 = errors;
        run_matrix(1'b1, 1'b1);
        end_test("ignored strobes", err0);

        err0 = errors;
        for (int k = 0; k < 3; k++) begin
            repeat ($random(seed) & 7) @(negedge clk);
            run_matrix(1'b0, 1'b0);
        end
        end_test("back to back", err0);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== source/n2r_input_stage.sv ====
// Input stage of the matrix-multiply accelerator
// Registers the incoming strobes and row, then reshapes through the buffer
`timescale 1ns/10ps

module n2r_input_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                row_valid,
    input  mx_pkg::row_t        in_row,
    output logic                out_valid,
    output logic                pair_done,
    output logic                done,
    output logic                busy,
    output mx_pkg::slice_beat_t out_beat
);

    logic         start_q;
    logic         row_valid_q;
    mx_pkg::row_t in_row_q;

    // Registered input strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q     <= 1'b0;
            row_valid_q <= 1'b0;
        end else begin
            start_q     <= start;
            row_valid_q <= row_valid;
        end
    end

    // Row data only moves with its strobe
    always_ff @(posedge clk) begin
        if (row_valid) begin
            in_row_q <= in_row;
        end
    end

    n2r_buffer_i u_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start_q),
        .row_valid (row_valid_q),
        .in_row    (in_row_q),
        .out_valid (out_valid),
        .pair_done (pair_done),
        .done      (done),
        .busy      (busy),
        .out_beat  (out_beat)
    );

endmodule

// ==== source/n2r_buffer_i.sv ====
// Normal-to-ready buffer for the input matrix
// Stores rows in order, then emits one 2x2 block per core on each beat
`timescale 1ns/10ps

module n2r_buffer_i (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                row_valid,
    input  mx_pkg::row_t        in_row,
    output logic                out_valid,
    output logic                pair_done,
    output logic                done,
    output logic                busy,
    output mx_pkg::slice_beat_t out_beat
);

    // Control tag that follows each read through the RAM and output register
    typedef struct packed {
        logic valid;
        logic last_pair;
        logic last_beat;
    } tag_t;

    mx_pkg::buf_state_t state_q;
    mx_pkg::buf_state_t state_d;

    mx_pkg::row_addr_t  row_cnt;
    mx_pkg::pair_idx_t  pair_idx;
    mx_pkg::group_idx_t group_idx;
    logic               drain_q;

    logic               ram_we;
    mx_pkg::row_addr_t  read_addr0;
    mx_pkg::row_addr_t  read_addr1;
    mx_pkg::row_t       ram_dout0;
    mx_pkg::row_t       ram_dout1;

    logic               issue;
    logic               last_row;
    logic               last_group;
    logic               last_pair_idx;
    tag_t               tag_in;
    tag_t [1:0]         tag_q;
    mx_pkg::group_idx_t grp_q;
    mx_pkg::slice_beat_t beat_d;
    logic               done_q;

    assign last_row      = (row_cnt == mx_pkg::row_addr_t'(mx_pkg::ROWS - 1));
    assign last_group    = (group_idx == mx_pkg::group_idx_t'(mx_pkg::GROUPS - 1));
    assign last_pair_idx = (pair_idx == mx_pkg::pair_idx_t'(mx_pkg::PAIRS - 1));

    // Addresses go out every SLICE cycle until the final beat is issued
    assign issue = (state_q == mx_pkg::SLICE) && !drain_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            mx_pkg::IDLE: begin
                if (start) begin
                    state_d = mx_pkg::FILL;
                end
            end
            mx_pkg::FILL: begin
                if (row_valid && last_row) begin
                    state_d = mx_pkg::SLICE;
                end
            end
            mx_pkg::SLICE: begin
                // Leave once the last beat has left the output register
                if (tag_q[1].valid && tag_q[1].last_beat) begin
                    state_d = mx_pkg::IDLE;
                end
            end
            default: state_d = mx_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= mx_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Row counter for the fill phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt <= '0;
        end else if (state_q == mx_pkg::IDLE && start) begin
            row_cnt <= '0;
        end else if (ram_we) begin
            row_cnt <= last_row ? '0 : row_cnt + 1'b1;
        end
    end

    // Column group steps first, row pair second
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            group_idx <= '0;
            pair_idx  <= '0;
            drain_q   <= 1'b0;
        end else if (state_q == mx_pkg::IDLE && start) begin
            group_idx <= '0;
            pair_idx  <= '0;
            drain_q   <= 1'b0;
        end else if (issue) begin
            if (last_group) begin
                group_idx <= '0;
                if (last_pair_idx) begin
                    pair_idx <= '0;
                    drain_q  <= 1'b1;
                end else begin
                    pair_idx <= pair_idx + 1'b1;
                end
            end else begin
                group_idx <= group_idx + 1'b1;
            end
        end
    end

    assign ram_we     = (state_q == mx_pkg::FILL) && row_valid;
    assign read_addr0 = mx_pkg::row_addr_t'(mx_pkg::BLOCK * pair_idx);
    assign read_addr1 = mx_pkg::row_addr_t'(mx_pkg::BLOCK * pair_idx + 1);

    row_ram u_ram (
        .clk        (clk),
        .we         (ram_we),
        .write_addr (row_cnt),
        .read_addr0 (read_addr0),
        .read_addr1 (read_addr1),
        .din        (in_row),
        .dout0      (ram_dout0),
        .dout1      (ram_dout1)
    );

    assign tag_in.valid     = issue;
    assign tag_in.last_pair = last_group;
    assign tag_in.last_beat = last_group && last_pair_idx;

    // Stage 0 lines up with RAM read data, stage 1 with the output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_q <= '0;
        end else begin
            tag_q[0] <= tag_in;
            tag_q[1] <= tag_q[0];
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            grp_q <= group_idx;
        end
    end

    // Lane c takes columns 2(g*NUM_CORES+c) and the next one from both rows
    always_comb begin
        mx_pkg::col_addr_t col;
        for (int c = 0; c < mx_pkg::NUM_CORES; c++) begin
            col = mx_pkg::col_addr_t'(mx_pkg::BLOCK * (int'(grp_q) * mx_pkg::NUM_CORES + c));
            beat_d[c].top_left  = ram_dout0[col];
            beat_d[c].top_right = ram_dout0[col + 1'b1];
            beat_d[c].bot_left  = ram_dout1[col];
            beat_d[c].bot_right = ram_dout1[col + 1'b1];
        end
    end

    always_ff @(posedge clk) begin
        if (tag_q[0].valid) begin
            out_beat <= beat_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= tag_q[1].valid && tag_q[1].last_beat;
        end
    end

    assign out_valid = tag_q[1].valid;
    assign pair_done = tag_q[1].valid && tag_q[1].last_pair;
    assign done      = done_q;
    assign busy      = (state_q != mx_pkg::IDLE);

endmodule

// ==== source/row_ram.sv ====
// Row storage RAM for the reshaping buffer
// One synchronous write port, two read ports with one cycle of latency
`timescale 1ns/10ps

module row_ram (
    input  logic                      clk,
    input  logic                      we,
    input  logic [mx_pkg::ROW_AW-1:0] write_addr,
    input  logic [mx_pkg::ROW_AW-1:0] read_addr0,
    input  logic [mx_pkg::ROW_AW-1:0] read_addr1,
    input  mx_pkg::row_t              din,
    output mx_pkg::row_t              dout0,
    output mx_pkg::row_t              dout1
);

    // One full matrix row per entry
    mx_pkg::row_t mem [mx_pkg::ROWS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[write_addr] <= din;
        end
    end

    // Upper row of the pair
    always_ff @(posedge clk) begin
        dout0 <= mem[read_addr0];
    end

    // Lower row of the pair
    always_ff @(posedge clk) begin
        dout1 <= mem[read_addr1];
    end

endmodule

// ==== source/mx_pkg.sv ====
// Matrix sizes, derived counts and shared types for the input reshaping buffer
package mx_pkg;

    // Matrix and block shape
    localparam int ELEM_W    = 16;
    localparam int BLOCK     = 2;
    localparam int NUM_CORES = 2;
    localparam int ROWS      = 8;
    localparam int COLS      = 8;

    // Derived counts
    localparam int PAIRS  = ROWS / BLOCK;
    localparam int GROUPS = COLS / (BLOCK * NUM_CORES);
    localparam int BEATS  = PAIRS * GROUPS;

    localparam int ROW_AW  = $clog2(ROWS);
    localparam int COL_AW  = $clog2(COLS);
    localparam int PAIR_W  = (PAIRS > 1) ? $clog2(PAIRS) : 1;
    localparam int GROUP_W = (GROUPS > 1) ? $clog2(GROUPS) : 1;

    typedef logic [ELEM_W-1:0] elem_t;

    // Element 0 in the low bits
    typedef elem_t [COLS-1:0] row_t;

    typedef struct packed {
        elem_t top_left;
        elem_t top_right;
        elem_t bot_left;
        elem_t bot_right;
    } block_t;

    // Lane 0 in the low bits
    typedef block_t [NUM_CORES-1:0] slice_beat_t;

    typedef logic [ROW_AW-1:0]  row_addr_t;
    typedef logic [COL_AW-1:0]  col_addr_t;
    typedef logic [PAIR_W-1:0]  pair_idx_t;
    typedef logic [GROUP_W-1:0] group_idx_t;

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        SLICE
    } buf_state_t;

endpackage
